/* list.f */
design/id_pkg.sv
design/decode_ctrl_if.sv
design/insn_decoder.sv
design/imm_gen.sv
design/id_ex_stage_reg.sv
design/id_stage.sv
verification/id_stage_assert.sv
verification/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - design/id_pkg.sv
  - design/decode_ctrl_if.sv
  - design/insn_decoder.sv
  - design/imm_gen.sv
  - design/id_ex_stage_reg.sv
  - design/id_stage.sv
  - target: test
    files:
      - verification/id_stage_assert.sv
      - verification/tb_id_stage.sv

/* verification/tb_id_stage.sv */
// Table-driven check of id_stage; register file answers in zero time, stimulus seed 24055
`default_nettype none

module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    // One stimulus row with its expected decode
    typedef struct packed {
        logic [31:0]     insn;
        id_pkg::word_t   pc;
        id_pkg::alu_op_e alu;
        id_pkg::cmp_op_e cmp;
        id_pkg::mem_op_e mem;
        id_pkg::wb_sel_e wb;
        logic            we;
        logic            jump;
        logic            ill;
        logic [1:0]      src;
        logic            pc_base;
        logic            use_imm;
        id_pkg::word_t   imm;
    } row_t;

    logic              clk_i;
    logic              rst_n_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [31:0]       insn_i;
    id_pkg::word_t     pc_i;
    id_pkg::reg_addr_t ra_addr_o;
    id_pkg::reg_addr_t rb_addr_o;
    id_pkg::word_t     ra_data_i;
    id_pkg::word_t     rb_data_i;
    logic              out_valid_o;
    logic              out_ready_i;
    id_pkg::alu_op_e   alu_op_o;
    id_pkg::word_t     alu_in_0_o;
    id_pkg::word_t     alu_in_1_o;
    id_pkg::cmp_op_e   cmp_op_o;
    id_pkg::word_t     cmp_in_0_o;
    id_pkg::word_t     cmp_in_1_o;
    id_pkg::mem_op_e   mem_op_o;
    id_pkg::word_t     mem_wr_data_o;
    id_pkg::wb_sel_e   wb_sel_o;
    logic              gpr_we_o;
    logic              jump_o;
    logic              illegal_o;
    id_pkg::reg_addr_t rd_addr_o;
    id_pkg::word_t     pc_o;
    logic [1:0]        src_used_o;

    id_pkg::word_t rf [32];            // GPR model, x0 stays zero
    row_t          rows [$];
    integer        seed        = 24055;
    logic          table_ready = 1'b0;

    id_stage DUT (.*);

    // Same-cycle register file reads
    assign ra_data_i = rf[ra_addr_o];
    assign rb_data_i = rf[rb_addr_o];

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // Instruction encoders, RV32I bit layout
    // ------------------------------------------------------------
    // Register fields rotate with the row count, x0 comes up at row 31
    function automatic logic [4:0] pick(input int k);
        return 5'((rows.size() + 1) * k);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, pick(7), pick(5), f3, pick(3), id_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm, pick(5), f3, pick(3), op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], pick(7), pick(5), f3, imm[4:0], id_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], pick(7), pick(5), f3, imm[4:1], imm[11],
                id_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], pick(3), id_pkg::OPC_JAL};
    endfunction

    // ------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------
    // flags = {gpr_we, jump, illegal}, base_imm = {pc_base, use_imm}
    task automatic add_row(input logic [31:0] insn, input id_pkg::alu_op_e alu,
                           input id_pkg::cmp_op_e cmp, input id_pkg::mem_op_e mem,
                           input id_pkg::wb_sel_e wb, input logic [2:0] flags,
                           input logic [1:0] src, input logic [1:0] base_imm,
                           input id_pkg::word_t imm);
        row_t          r;
        id_pkg::word_t pc;
        pc = 32'h0001_0000 + 32'(rows.size() * 4);
        r  = '{insn, pc, alu, cmp, mem, wb, flags[2], flags[1], flags[0], src,
               base_imm[1], base_imm[0], imm};
        rows.push_back(r);
    endtask

    task automatic r_row(input logic [6:0] f7, input logic [2:0] f3,
                         input id_pkg::alu_op_e alu, input id_pkg::cmp_op_e cmp);
        id_pkg::wb_sel_e wb;
        wb = id_pkg::WB_ALU;
        if (cmp != id_pkg::CMP_NOP) begin
            wb = id_pkg::WB_CMP;  // SLT and SLTU
        end
        add_row(enc_r(f7, f3), alu, cmp, id_pkg::MEM_NOP, wb, 3'b100, 2'b11, 2'b00, '0);
    endtask

    task automatic i_row(input logic [11:0] imm, input logic [2:0] f3,
                         input id_pkg::alu_op_e alu, input id_pkg::cmp_op_e cmp,
                         input id_pkg::word_t exp_imm);
        id_pkg::wb_sel_e wb;
        wb = id_pkg::WB_ALU;
        if (cmp != id_pkg::CMP_NOP) begin
            wb = id_pkg::WB_CMP;
        end
        add_row(enc_i(imm, f3, id_pkg::OPC_OP_IMM), alu, cmp, id_pkg::MEM_NOP, wb,
                3'b100, 2'b01, 2'b01, exp_imm);
    endtask

    task automatic ld_row(input logic [11:0] imm, input logic [2:0] f3,
                          input id_pkg::mem_op_e mem, input id_pkg::word_t exp_imm);
        add_row(enc_i(imm, f3, id_pkg::OPC_LOAD), id_pkg::ALU_ADD, id_pkg::CMP_NOP, mem,
                id_pkg::WB_ALU, 3'b100, 2'b01, 2'b01, exp_imm);
    endtask

    task automatic st_row(input logic [11:0] imm, input logic [2:0] f3,
                          input id_pkg::mem_op_e mem, input id_pkg::word_t exp_imm);
        add_row(enc_s(imm, f3), id_pkg::ALU_ADD, id_pkg::CMP_NOP, mem,
                id_pkg::WB_ALU, 3'b000, 2'b11, 2'b01, exp_imm);
    endtask

    task automatic br_row(input logic [12:0] imm, input logic [2:0] f3,
                          input id_pkg::cmp_op_e cmp, input id_pkg::word_t exp_imm);
        add_row(enc_b(imm, f3), id_pkg::ALU_ADD, cmp, id_pkg::MEM_NOP,
                id_pkg::WB_ALU, 3'b000, 2'b11, 2'b11, exp_imm);
    endtask

    task automatic ill_row(input logic [31:0] insn);
        add_row(insn, id_pkg::ALU_NOP, id_pkg::CMP_NOP, id_pkg::MEM_NOP,
                id_pkg::WB_ALU, 3'b001, 2'b00, 2'b00, '0);
    endtask

    task automatic build_table();
        r_row(7'h00, 3'd0, id_pkg::ALU_ADD, id_pkg::CMP_NOP);
        r_row(7'h20, 3'd0, id_pkg::ALU_SUB, id_pkg::CMP_NOP);
        r_row(7'h00, 3'd1, id_pkg::ALU_SLL, id_pkg::CMP_NOP);
        r_row(7'h00, 3'd2, id_pkg::ALU_NOP, id_pkg::CMP_LT);
        r_row(7'h00, 3'd3, id_pkg::ALU_NOP, id_pkg::CMP_LTU);
        r_row(7'h00, 3'd4, id_pkg::ALU_XOR, id_pkg::CMP_NOP);
        r_row(7'h00, 3'd5, id_pkg::ALU_SRL, id_pkg::CMP_NOP);
        r_row(7'h20, 3'd5, id_pkg::ALU_SRA, id_pkg::CMP_NOP);
        r_row(7'h00, 3'd6, id_pkg::ALU_OR, id_pkg::CMP_NOP);
        r_row(7'h00, 3'd7, id_pkg::ALU_AND, id_pkg::CMP_NOP);
        i_row(12'hFFC, 3'd0, id_pkg::ALU_ADD, id_pkg::CMP_NOP, 32'hFFFF_FFFC);
        i_row(12'h7FF, 3'd2, id_pkg::ALU_NOP, id_pkg::CMP_LT, 32'h0000_07FF);
        i_row(12'h800, 3'd3, id_pkg::ALU_NOP, id_pkg::CMP_LTU, 32'hFFFF_F800);
        i_row(12'h123, 3'd4, id_pkg::ALU_XOR, id_pkg::CMP_NOP, 32'h0000_0123);
        i_row(12'hA5A, 3'd6, id_pkg::ALU_OR, id_pkg::CMP_NOP, 32'hFFFF_FA5A);
        i_row(12'h0F0, 3'd7, id_pkg::ALU_AND, id_pkg::CMP_NOP, 32'h0000_00F0);
        i_row(12'h01F, 3'd1, id_pkg::ALU_SLL, id_pkg::CMP_NOP, 32'd31);  // shamt unsigned
        i_row(12'h005, 3'd5, id_pkg::ALU_SRL, id_pkg::CMP_NOP, 32'd5);
        i_row(12'h41F, 3'd5, id_pkg::ALU_SRA, id_pkg::CMP_NOP, 32'd31);
        ld_row(12'h010, 3'd0, id_pkg::MEM_LB, 32'h0000_0010);
        ld_row(12'hFFE, 3'd1, id_pkg::MEM_LH, 32'hFFFF_FFFE);
        ld_row(12'h7FC, 3'd2, id_pkg::MEM_LW, 32'h0000_07FC);
        ld_row(12'h800, 3'd4, id_pkg::MEM_LBU, 32'hFFFF_F800);
        ld_row(12'h002, 3'd5, id_pkg::MEM_LHU, 32'h0000_0002);
        st_row(12'hFFF, 3'd0, id_pkg::MEM_SB, 32'hFFFF_FFFF);
        st_row(12'h7E0, 3'd1, id_pkg::MEM_SH, 32'h0000_07E0);
        st_row(12'h81F, 3'd2, id_pkg::MEM_SW, 32'hFFFF_F81F);
        br_row(13'h0008, 3'd0, id_pkg::CMP_EQ, 32'h0000_0008);
        br_row(13'h1FF8, 3'd1, id_pkg::CMP_NE, 32'hFFFF_FFF8);
        br_row(13'h0FFE, 3'd4, id_pkg::CMP_LT, 32'h0000_0FFE);
        br_row(13'h1000, 3'd5, id_pkg::CMP_GE, 32'hFFFF_F000);
        br_row(13'h0802, 3'd6, id_pkg::CMP_LTU, 32'h0000_0802);
        br_row(13'h17FE, 3'd7, id_pkg::CMP_GEU, 32'hFFFF_F7FE);
        add_row(enc_j(21'h1A_BCDE), id_pkg::ALU_ADD, id_pkg::CMP_NOP, id_pkg::MEM_NOP,
                id_pkg::WB_PC_LINK, 3'b110, 2'b00, 2'b11, 32'hFFFA_BCDE);
        // Odd JALR offset passes through, execute clears bit 0
        add_row(enc_i(12'h801, 3'd0, id_pkg::OPC_JALR), id_pkg::ALU_ADD, id_pkg::CMP_NOP,
                id_pkg::MEM_NOP, id_pkg::WB_PC_LINK, 3'b110, 2'b01, 2'b01, 32'hFFFF_F801);
        ill_row(32'h0000_0037);                            // LUI
        ill_row(32'h0000_0073);                            // ECALL
        ill_row(enc_r(7'h20, 3'd1));
        ill_row(enc_i(12'h000, 3'd3, id_pkg::OPC_LOAD));
        ill_row(enc_b(13'h0004, 3'd2));
        ill_row(enc_i(12'h000, 3'd1, id_pkg::OPC_JALR));
    endtask

    // ------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Compare all outputs with row n
    task automatic check_row(input int n);
        row_t          r;
        id_pkg::word_t ra;
        id_pkg::word_t rb;
        string         tag;
        r   = rows[n];
        ra  = rf[r.insn[19:15]];
        rb  = rf[r.insn[24:20]];
        tag = $sformatf("row %0d ", n);
        check_value({tag, "alu_op"}, alu_op_o, r.alu);
        check_value({tag, "alu_in_0"}, alu_in_0_o, r.pc_base ? r.pc : ra);
        check_value({tag, "alu_in_1"}, alu_in_1_o, r.use_imm ? r.imm : rb);
        check_value({tag, "cmp_op"}, cmp_op_o, r.cmp);
        check_value({tag, "cmp_in_0"}, cmp_in_0_o, ra);
        check_value({tag, "cmp_in_1"}, cmp_in_1_o, rb);
        check_value({tag, "mem_op"}, mem_op_o, r.mem);
        check_value({tag, "mem_wr_data"}, mem_wr_data_o, rb);
        check_value({tag, "wb_sel"}, wb_sel_o, r.wb);
        check_value({tag, "gpr_we"}, gpr_we_o, r.we);
        check_value({tag, "jump"}, jump_o, r.jump);
        check_value({tag, "illegal"}, illegal_o, r.ill);
        check_value({tag, "rd_addr"}, rd_addr_o, r.insn[11:7]);
        check_value({tag, "pc"}, pc_o, r.pc);
        check_value({tag, "src_used"}, src_used_o, r.src);
    endtask

    // ------------------------------------------------------------
    // Upstream driver and downstream receiver
    // ------------------------------------------------------------
    task automatic drive_rows();
        int i;
        i = 0;
        while (i < rows.size()) begin
            @(negedge clk_i);
            in_valid_i = 1'b1;
            insn_i     = rows[i].insn;
            pc_i       = rows[i].pc;
            #1;
            check_value("ra_addr_o", ra_addr_o, rows[i].insn[19:15]);  // rs1 field
            check_value("rb_addr_o", rb_addr_o, rows[i].insn[24:20]);  // rs2 field
            if (in_ready_o) begin
                i++;  // Accepted on the coming rising edge
            end
        end
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic receive_rows();
        int n;
        n = 0;
        while (n < rows.size()) begin
            @(negedge clk_i);
            out_ready_i = ($random(seed) & 3) != 0;  // Ready about 3 cycles in 4
            #1;
            if (out_valid_o) begin
                check_row(n);  // Every stalled cycle too
                if (out_ready_i) begin
                    n++;
                end
            end
        end
    endtask

    initial begin : main
        int i;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        insn_i      = '0;
        pc_i        = '0;
        rf[0]       = '0;
        for (i = 1; i < 32; i++) begin
            rf[i] = $random(seed);
        end
        build_table();
        table_ready = 1'b1;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        check_value("out_valid_o after reset", out_valid_o, 1'b0);
        check_value("in_ready_o after reset", in_ready_o, 1'b1);
        check_value("gpr_we_o after reset", gpr_we_o, 1'b0);
        check_value("jump_o after reset", jump_o, 1'b0);
        fork
            drive_rows();
            receive_rows();
        join
        @(negedge clk_i);
        #1;
        check_value("out_valid_o after last row", out_valid_o, 1'b0);  // No extra output
        $display("All tests passed");
        $finish;
    end

    // Reset time plus 20 cycles per row
    initial begin : watchdog
        wait (table_ready);
        repeat (rows.size() * 20 + 8) @(posedge clk_i);
        $display("Timeout: not all rows came out within %0d cycles", rows.size() * 20 + 8);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* verification/id_stage_assert.sv */
// Handshake and reset properties only; decode values are checked by the testbench
`default_nettype none

module id_stage_assert (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              in_valid_i,
    input logic              in_ready_o,
    input logic              out_valid_o,
    input logic              out_ready_i,
    input id_pkg::alu_op_e   alu_op_o,
    input id_pkg::word_t     alu_in_0_o,
    input id_pkg::word_t     alu_in_1_o,
    input id_pkg::cmp_op_e   cmp_op_o,
    input id_pkg::word_t     cmp_in_0_o,
    input id_pkg::word_t     cmp_in_1_o,
    input id_pkg::mem_op_e   mem_op_o,
    input id_pkg::word_t     mem_wr_data_o,
    input id_pkg::wb_sel_e   wb_sel_o,
    input logic              gpr_we_o,
    input logic              jump_o,
    input logic              illegal_o,
    input id_pkg::reg_addr_t rd_addr_o,
    input id_pkg::word_t     pc_o,
    input logic [1:0]        src_used_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------
    a_reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_o)
        else $error("out_valid_o not low in the cycle after reset");

    a_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && in_ready_o |=> out_valid_o)
        else $error("accepted instruction not valid one cycle later");

    // Whole output bundle frozen during a stall
    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o &&
        $stable({alu_op_o, alu_in_0_o, alu_in_1_o, cmp_op_o, cmp_in_0_o, cmp_in_1_o,
                 mem_op_o, mem_wr_data_o, wb_sel_o, gpr_we_o, jump_o, illegal_o,
                 rd_addr_o, pc_o, src_used_o}))
        else $error("outputs changed while stalled");

    a_we_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(gpr_we_o && illegal_o))
        else $error("gpr_we_o and illegal_o both high");

endmodule

bind id_stage id_stage_assert u_id_stage_assert (.*);

`default_nettype wire

/* design/id_stage.sv */
// RV32I decode stage; register file read is external and must answer in the same cycle
`default_nettype none

module id_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    // Upstream
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [31:0]       insn_i,
    input  id_pkg::word_t     pc_i,
    // Register file
    output id_pkg::reg_addr_t ra_addr_o,
    output id_pkg::reg_addr_t rb_addr_o,
    input  id_pkg::word_t     ra_data_i,
    input  id_pkg::word_t     rb_data_i,
    // Downstream
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output id_pkg::alu_op_e   alu_op_o,
    output id_pkg::word_t     alu_in_0_o,
    output id_pkg::word_t     alu_in_1_o,
    output id_pkg::cmp_op_e   cmp_op_o,
    output id_pkg::word_t     cmp_in_0_o,
    output id_pkg::word_t     cmp_in_1_o,
    output id_pkg::mem_op_e   mem_op_o,
    output id_pkg::word_t     mem_wr_data_o,
    output id_pkg::wb_sel_e   wb_sel_o,
    output logic              gpr_we_o,
    output logic              jump_o,
    output logic              illegal_o,
    output id_pkg::reg_addr_t rd_addr_o,
    output id_pkg::word_t     pc_o,
    output logic [1:0]        src_used_o
);

    id_pkg::insn_u    insn;
    id_pkg::imm_sel_e imm_sel;
    id_pkg::word_t    imm;

    decode_ctrl_if ctrl_if ();

    assign insn      = insn_i;
    assign ra_addr_o = insn.r.rs1;  // Read ports follow insn_i directly
    assign rb_addr_o = insn.r.rs2;

    insn_decoder u_insn_decoder (
        .insn_i    (insn),
        .ctrl      (ctrl_if.decoder),
        .imm_sel_o (imm_sel)
    );

    imm_gen u_imm_gen (
        .insn_i    (insn),
        .imm_sel_i (imm_sel),
        .imm_o     (imm)
    );

    id_ex_stage_reg u_id_ex_stage_reg (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .pc_i          (pc_i),
        .rd_i          (insn.r.rd),
        .ra_data_i     (ra_data_i),
        .rb_data_i     (rb_data_i),
        .imm_i         (imm),
        .ctrl          (ctrl_if.stage),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .alu_op_o      (alu_op_o),
        .alu_in_0_o    (alu_in_0_o),
        .alu_in_1_o    (alu_in_1_o),
        .cmp_op_o      (cmp_op_o),
        .cmp_in_0_o    (cmp_in_0_o),
        .cmp_in_1_o    (cmp_in_1_o),
        .mem_op_o      (mem_op_o),
        .mem_wr_data_o (mem_wr_data_o),
        .wb_sel_o      (wb_sel_o),
        .gpr_we_o      (gpr_we_o),
        .jump_o        (jump_o),
        .illegal_o     (illegal_o),
        .rd_addr_o     (rd_addr_o),
        .pc_o          (pc_o),
        .src_used_o    (src_used_o)
    );

endmodule

`default_nettype wire

/* design/id_ex_stage_reg.sv */
// One-entry output register; operand data must be valid in the cycle in_valid_i is high
`default_nettype none

module id_ex_stage_reg (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  id_pkg::word_t     pc_i,
    input  id_pkg::reg_addr_t rd_i,
    input  id_pkg::word_t     ra_data_i,
    input  id_pkg::word_t     rb_data_i,
    input  id_pkg::word_t     imm_i,
    decode_ctrl_if.stage      ctrl,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output id_pkg::alu_op_e   alu_op_o,
    output id_pkg::word_t     alu_in_0_o,
    output id_pkg::word_t     alu_in_1_o,
    output id_pkg::cmp_op_e   cmp_op_o,
    output id_pkg::word_t     cmp_in_0_o,
    output id_pkg::word_t     cmp_in_1_o,
    output id_pkg::mem_op_e   mem_op_o,
    output id_pkg::word_t     mem_wr_data_o,
    output id_pkg::wb_sel_e   wb_sel_o,
    output logic              gpr_we_o,
    output logic              jump_o,
    output logic              illegal_o,
    output id_pkg::reg_addr_t rd_addr_o,
    output id_pkg::word_t     pc_o,
    output logic [1:0]        src_used_o
);

    logic accept;

    // Free slot, or the slot drains this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    // ----------------------------------------------------------
    // Handshake state and control flags
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            gpr_we_o    <= 1'b0;
            jump_o      <= 1'b0;
            illegal_o   <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            gpr_we_o    <= ctrl.gpr_we;
            jump_o      <= ctrl.jump;
            illegal_o   <= ctrl.illegal;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;  // Drained, nothing new
        end
    end

    // ----------------------------------------------------------
    // Operand selection and payload
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (accept) begin
            alu_op_o      <= ctrl.alu_op;
            alu_in_0_o    <= ctrl.pc_base ? pc_i : ra_data_i;
            alu_in_1_o    <= ctrl.use_imm ? imm_i : rb_data_i;
            cmp_op_o      <= ctrl.cmp_op;
            cmp_in_0_o    <= ra_data_i;
            cmp_in_1_o    <= rb_data_i;
            mem_op_o      <= ctrl.mem_op;
            mem_wr_data_o <= rb_data_i;  // Store data
            wb_sel_o      <= ctrl.wb_sel;
            rd_addr_o     <= rd_i;
            pc_o          <= pc_i;
            src_used_o    <= ctrl.src_used;
        end
    end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
// No U format; SHAMT is zero-extended and the B/J immediates keep bit 0 at zero
`default_nettype none

module imm_gen (
    input  id_pkg::insn_u    insn_i,
    input  id_pkg::imm_sel_e imm_sel_i,
    output id_pkg::word_t    imm_o
);

    id_pkg::insn_i_t iw;
    id_pkg::insn_s_t sw;

    assign iw = insn_i.i;
    assign sw = insn_i.s;

    always_comb begin
        case (imm_sel_i)
            id_pkg::IMM_I:     imm_o = {{20{iw.imm12[11]}}, iw.imm12};
            id_pkg::IMM_SHAMT: imm_o = {27'b0, iw.imm12[4:0]};  // insn[24:20]
            id_pkg::IMM_S:     imm_o = {{20{sw.imm_hi[6]}}, sw.imm_hi, sw.imm_lo};
            // imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
            id_pkg::IMM_B: begin
                imm_o = {{19{sw.imm_hi[6]}}, sw.imm_hi[6], sw.imm_lo[0],
                         sw.imm_hi[5:0], sw.imm_lo[4:1], 1'b0};
            end
            // imm[20|10:1|11|19:12] sits in insn[31:12]
            id_pkg::IMM_J: begin
                imm_o = {{11{iw.imm12[11]}}, iw.imm12[11], iw.rs1, iw.funct3,
                         iw.imm12[0], iw.imm12[10:1], 1'b0};
            end
            default:           imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/insn_decoder.sv */
// RV32I subset without LUI/AUIPC, FENCE and SYSTEM; anything else decodes as an illegal no-op
`default_nettype none

module insn_decoder (
    input  id_pkg::insn_u    insn_i,
    decode_ctrl_if.decoder   ctrl,
    output id_pkg::imm_sel_e imm_sel_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       bad;

    assign opcode = insn_i.i.opcode;
    assign funct3 = insn_i.i.funct3;
    assign funct7 = insn_i.r.funct7;  // Also the upper imm bits of shifts

    always_comb begin
        // No-op defaults
        bad           = 1'b0;
        ctrl.alu_op   = id_pkg::ALU_NOP;
        ctrl.cmp_op   = id_pkg::CMP_NOP;
        ctrl.mem_op   = id_pkg::MEM_NOP;
        ctrl.wb_sel   = id_pkg::WB_ALU;
        ctrl.gpr_we   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.src_used = 2'b00;
        ctrl.pc_base  = 1'b0;
        ctrl.use_imm  = 1'b0;
        imm_sel_o     = id_pkg::IMM_NONE;

        case (opcode)
            id_pkg::OPC_LOAD: begin
                ctrl.src_used = 2'b01;
                ctrl.alu_op   = id_pkg::ALU_ADD;  // Address = rs1 + imm
                ctrl.use_imm  = 1'b1;
                ctrl.gpr_we   = 1'b1;
                imm_sel_o     = id_pkg::IMM_I;
                case (funct3)
                    3'b000:  ctrl.mem_op = id_pkg::MEM_LB;
                    3'b001:  ctrl.mem_op = id_pkg::MEM_LH;
                    3'b010:  ctrl.mem_op = id_pkg::MEM_LW;
                    3'b100:  ctrl.mem_op = id_pkg::MEM_LBU;
                    3'b101:  ctrl.mem_op = id_pkg::MEM_LHU;
                    default: bad = 1'b1;
                endcase
            end
            id_pkg::OPC_OP_IMM: begin
                ctrl.src_used = 2'b01;
                ctrl.use_imm  = 1'b1;
                ctrl.gpr_we   = 1'b1;
                imm_sel_o     = id_pkg::IMM_I;
                case (funct3)
                    3'b000: ctrl.alu_op = id_pkg::ALU_ADD;
                    3'b010: begin
                        ctrl.cmp_op = id_pkg::CMP_LT;
                        ctrl.wb_sel = id_pkg::WB_CMP;
                    end
                    3'b011: begin
                        ctrl.cmp_op = id_pkg::CMP_LTU;
                        ctrl.wb_sel = id_pkg::WB_CMP;
                    end
                    3'b100: ctrl.alu_op = id_pkg::ALU_XOR;
                    3'b110: ctrl.alu_op = id_pkg::ALU_OR;
                    3'b111: ctrl.alu_op = id_pkg::ALU_AND;
                    3'b001: begin
                        ctrl.alu_op = id_pkg::ALU_SLL;
                        imm_sel_o   = id_pkg::IMM_SHAMT;
                        bad         = (funct7 != 7'b0000000);
                    end
                    default: begin // SRLI / SRAI
                        imm_sel_o = id_pkg::IMM_SHAMT;
                        if (funct7 == 7'b0000000) ctrl.alu_op = id_pkg::ALU_SRL;
                        else if (funct7 == 7'b0100000) ctrl.alu_op = id_pkg::ALU_SRA;
                        else bad = 1'b1;
                    end
                endcase
            end
            id_pkg::OPC_OP: begin
                ctrl.src_used = 2'b11;
                ctrl.gpr_we   = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = funct7[5] ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
                    3'b001: ctrl.alu_op = id_pkg::ALU_SLL;
                    3'b010: begin
                        ctrl.cmp_op = id_pkg::CMP_LT;
                        ctrl.wb_sel = id_pkg::WB_CMP;
                    end
                    3'b011: begin
                        ctrl.cmp_op = id_pkg::CMP_LTU;
                        ctrl.wb_sel = id_pkg::WB_CMP;
                    end
                    3'b100: ctrl.alu_op = id_pkg::ALU_XOR;
                    3'b101: ctrl.alu_op = funct7[5] ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                    3'b110: ctrl.alu_op = id_pkg::ALU_OR;
                    default: ctrl.alu_op = id_pkg::ALU_AND;
                endcase
                // funct7 bit 5 is only valid for SUB and SRA
                bad = ((funct7 & 7'b1011111) != 7'b0000000) ||
                      (funct7[5] && (funct3 != 3'b000) && (funct3 != 3'b101));
            end
            id_pkg::OPC_STORE: begin
                ctrl.src_used = 2'b11;
                ctrl.alu_op   = id_pkg::ALU_ADD;
                ctrl.use_imm  = 1'b1;
                imm_sel_o     = id_pkg::IMM_S;
                case (funct3)
                    3'b000:  ctrl.mem_op = id_pkg::MEM_SB;
                    3'b001:  ctrl.mem_op = id_pkg::MEM_SH;
                    3'b010:  ctrl.mem_op = id_pkg::MEM_SW;
                    default: bad = 1'b1;
                endcase
            end
            id_pkg::OPC_BRANCH: begin
                ctrl.src_used = 2'b11;
                ctrl.alu_op   = id_pkg::ALU_ADD;  // Target = pc + imm
                ctrl.pc_base  = 1'b1;
                ctrl.use_imm  = 1'b1;
                imm_sel_o     = id_pkg::IMM_B;
                case (funct3)
                    3'b000:  ctrl.cmp_op = id_pkg::CMP_EQ;
                    3'b001:  ctrl.cmp_op = id_pkg::CMP_NE;
                    3'b100:  ctrl.cmp_op = id_pkg::CMP_LT;
                    3'b101:  ctrl.cmp_op = id_pkg::CMP_GE;
                    3'b110:  ctrl.cmp_op = id_pkg::CMP_LTU;
                    3'b111:  ctrl.cmp_op = id_pkg::CMP_GEU;
                    default: bad = 1'b1;
                endcase
            end
            id_pkg::OPC_JAL: begin
                ctrl.alu_op  = id_pkg::ALU_ADD;
                ctrl.pc_base = 1'b1;
                ctrl.use_imm = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.wb_sel  = id_pkg::WB_PC_LINK;
                ctrl.gpr_we  = 1'b1;
                imm_sel_o    = id_pkg::IMM_J;
            end
            id_pkg::OPC_JALR: begin
                ctrl.src_used = 2'b01;
                ctrl.alu_op   = id_pkg::ALU_ADD;  // Execute clears bit 0 of the sum
                ctrl.use_imm  = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.wb_sel   = id_pkg::WB_PC_LINK;
                ctrl.gpr_we   = 1'b1;
                imm_sel_o     = id_pkg::IMM_I;
                bad           = (funct3 != 3'b000);
            end
            default: bad = 1'b1;
        endcase

        // Undefined encodings fall back to a plain no-op
        if (bad) begin
            ctrl.alu_op   = id_pkg::ALU_NOP;
            ctrl.cmp_op   = id_pkg::CMP_NOP;
            ctrl.mem_op   = id_pkg::MEM_NOP;
            ctrl.wb_sel   = id_pkg::WB_ALU;
            ctrl.gpr_we   = 1'b0;
            ctrl.jump     = 1'b0;
            ctrl.src_used = 2'b00;
            ctrl.pc_base  = 1'b0;
            ctrl.use_imm  = 1'b0;
            imm_sel_o     = id_pkg::IMM_NONE;
        end
        ctrl.illegal = bad;
    end

endmodule

`default_nettype wire

/* design/decode_ctrl_if.sv */
// Purely combinational bundle, no clock; driven by one decoder only
`default_nettype none

interface decode_ctrl_if;

    id_pkg::alu_op_e alu_op;
    id_pkg::cmp_op_e cmp_op;
    id_pkg::mem_op_e mem_op;
    id_pkg::wb_sel_e wb_sel;
    logic            gpr_we;
    logic            jump;
    logic            illegal;
    logic [1:0]      src_used;  // Bit 0 rs1, bit 1 rs2
    logic            pc_base;   // ALU operand 0 is pc
    logic            use_imm;   // ALU operand 1 is the immediate

    modport decoder (
        output alu_op, cmp_op, mem_op, wb_sel, gpr_we, jump, illegal, src_used,
               pc_base, use_imm
    );

    modport stage (
        input alu_op, cmp_op, mem_op, wb_sel, gpr_we, jump, illegal, src_used,
              pc_base, use_imm
    );

endinterface

`default_nettype wire

/* design/id_pkg.sv */
// RV32 only; every enum encoding here is shared with the execute stage and must match it
`default_nettype none

package id_pkg;

    // ----------------------------------------------------------
    // Widths and basic types
    // ----------------------------------------------------------
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;      // Data word or pc
    typedef logic [4:0]      reg_addr_t;  // GPR index

    // Major opcodes of the kept instruction groups
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // ----------------------------------------------------------
    // Control encodings seen by execute
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        CMP_NOP, CMP_EQ, CMP_NE, CMP_LT, CMP_GE, CMP_LTU, CMP_GEU
    } cmp_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // Execute forms pc+4 itself for PC_LINK
    typedef enum logic [1:0] {
        WB_ALU, WB_CMP, WB_PC_LINK
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_J
    } imm_sel_e;

    // ----------------------------------------------------------
    // Instruction word views
    // ----------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } insn_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;  // B format reuses these bits
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } insn_s_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
        insn_s_t s;
    } insn_u;

endpackage

`default_nettype wire
